//--- hw/ex_pkg.sv
package ex_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  size_t;
    typedef logic [6:0]  except_t; // [6] ale, [5:0] from decode

    localparam size_t size_byte = 2'd0;
    localparam size_t size_half = 2'd1;
    localparam size_t size_word = 2'd2;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_nor, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [2:0] {
        md_none, md_mul, md_mulh, md_mulhu,
        md_div, md_mod, md_divu, md_modu
    } md_op_e;

    // nine codes, so one bit wider than a 3-bit field
    typedef enum logic [3:0] {
        mem_none,
        mem_ld_b, mem_ld_bu, mem_ld_h, mem_ld_hu, mem_ld_w,
        mem_st_b, mem_st_h, mem_st_w
    } mem_op_e;

    typedef enum logic [1:0] {
        div_idle, div_busy, div_done
    } div_state_e;

    function automatic logic md_is_mul(md_op_e op);
        return op inside {md_mul, md_mulh, md_mulhu};
    endfunction

    function automatic logic md_is_div(md_op_e op);
        return op inside {md_div, md_mod, md_divu, md_modu};
    endfunction

endpackage

//--- hw/muldiv_if.sv
interface muldiv_if
    import ex_pkg::*;
();

    logic   start;  // one cycle, first cycle of a divide
    md_op_e op;
    word_t  src1;
    word_t  src2;
    logic   busy;
    word_t  result;
    logic   done;   // level, held until next start

    modport stage (
        output start, op, src1, src2,
        input  busy, result, done
    );

    modport unit (
        input  start, op, src1, src2,
        output busy, result, done
    );

endinterface

//--- hw/alu.sv
module alu
    import ex_pkg::*;
(
    input  alu_op_e alu_op,
    input  word_t   alu_src1,
    input  word_t   alu_src2,
    output word_t   alu_result
);

    word_t      add_sub_result;
    logic [4:0] shamt;

    assign shamt = alu_src2[4:0];

    // sub shares the adder through inversion and carry in
    assign add_sub_result = alu_src1 + (alu_op == alu_sub ? ~alu_src2 : alu_src2)
                            + {31'b0, alu_op == alu_sub};

    always_comb begin
        case (alu_op)
            alu_add,
            alu_sub: begin
                alu_result = add_sub_result;
            end
            alu_slt: begin
                alu_result = {31'b0, $signed(alu_src1) < $signed(alu_src2)};
            end
            alu_sltu: begin
                alu_result = {31'b0, alu_src1 < alu_src2};
            end
            alu_and: begin
                alu_result = alu_src1 & alu_src2;
            end
            alu_nor: begin
                alu_result = ~(alu_src1 | alu_src2);
            end
            alu_or: begin
                alu_result = alu_src1 | alu_src2;
            end
            alu_xor: begin
                alu_result = alu_src1 ^ alu_src2;
            end
            alu_sll: begin
                alu_result = alu_src1 << shamt;
            end
            alu_srl: begin
                alu_result = alu_src1 >> shamt;
            end
            alu_sra: begin
                alu_result = word_t'($signed(alu_src1) >>> shamt);
            end
            alu_lui: begin
                alu_result = alu_src2; // imm already shifted by decode
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

endmodule

//--- hw/muldiv_unit.sv
module muldiv_unit
    import ex_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    muldiv_if.unit md
);

    div_state_e  state;
    logic [4:0]  step;
    logic        take_start;
    logic        src_signed;
    word_t       src1_mag;
    word_t       src2_mag;
    md_op_e      div_op;
    logic        quot_neg;
    logic        rem_neg;
    word_t       divisor;
    word_t       quot;
    word_t       rem;
    logic [32:0] rem_shift;
    logic [32:0] trial;
    dword_t      prod_s;
    dword_t      prod_u;
    word_t       mul_result;
    word_t       div_result;

    // multiplier
    assign prod_u = {32'b0, md.src1} * {32'b0, md.src2};
    assign prod_s = dword_t'($signed({{32{md.src1[31]}}, md.src1})
                           * $signed({{32{md.src2[31]}}, md.src2}));

    always_comb begin
        case (md.op)
            md_mul:   mul_result = prod_s[31:0];
            md_mulh:  mul_result = prod_s[63:32];
            md_mulhu: mul_result = prod_u[63:32];
            default:  mul_result = '0;
        endcase
    end

    // divider works on magnitudes
    assign src_signed = md.op inside {md_div, md_mod};
    assign src1_mag   = (src_signed && md.src1[31]) ? -md.src1 : md.src1;
    assign src2_mag   = (src_signed && md.src2[31]) ? -md.src2 : md.src2;
    assign take_start = md.start && (state != div_busy);

    assign rem_shift = {rem, quot[31]};
    assign trial     = rem_shift - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= div_idle;
            step  <= '0;
        end else begin
            case (state)
                div_idle,
                div_done: begin
                    if (take_start) begin
                        state <= div_busy;
                        step  <= '0;
                    end
                end
                div_busy: begin
                    if (step == 5'd31) begin
                        state <= div_done;
                    end
                    step <= step + 5'd1;
                end
                default: state <= div_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_start) begin
            div_op   <= md.op;
            divisor  <= src2_mag;
            quot     <= src1_mag; // dividend shifts out as quotient shifts in
            rem      <= '0;
            quot_neg <= src_signed & (md.src1[31] ^ md.src2[31]);
            rem_neg  <= src_signed & md.src1[31];
        end else if (state == div_busy) begin
            if (trial[32]) begin // restore
                rem  <= rem_shift[31:0];
                quot <= {quot[30:0], 1'b0};
            end else begin
                rem  <= trial[31:0];
                quot <= {quot[30:0], 1'b1};
            end
        end
    end

    always_comb begin
        if (div_op inside {md_div, md_divu}) begin
            div_result = quot_neg ? -quot : quot;
        end else begin
            div_result = rem_neg ? -rem : rem;
        end
    end

    assign md.result = md_is_mul(md.op) ? mul_result : div_result;
    assign md.busy   = (state == div_busy);
    assign md.done   = md_is_mul(md.op) || (state == div_done);

endmodule

//--- hw/ex_stage.sv
module ex_stage
    import ex_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       ds_valid,
    output logic       es_allowin,
    input  alu_op_e    ds_alu_op,
    input  md_op_e     ds_md_op,
    input  mem_op_e    ds_mem_op,
    input  word_t      ds_src1,
    input  word_t      ds_src2,
    input  word_t      ds_rkd_value,
    input  logic       ds_rf_we,
    input  reg_addr_t  ds_rf_waddr,
    input  word_t      ds_pc,
    input  logic [5:0] ds_except,
    input  logic       ds_rdcnt_lo,
    input  logic       ds_rdcnt_hi,
    input  logic       ms_allowin,
    input  logic       except_flush,
    output logic       es_to_ms_valid,
    output word_t      es_pc,
    output word_t      es_result,
    output logic       es_rf_we,
    output reg_addr_t  es_rf_waddr,
    output logic       es_res_from_mem,
    output mem_op_e    es_mem_op,
    output except_t    es_except,
    output logic       data_sram_req,
    output logic       data_sram_wr,
    output size_t      data_sram_size,
    output strb_t      data_sram_wstrb,
    output word_t      data_sram_addr,
    output word_t      data_sram_wdata,
    input  logic       data_sram_addr_ok,
    muldiv_if.stage    md
);

    logic       es_valid;
    logic       es_ready_go;
    alu_op_e    es_alu_op;
    md_op_e     es_md_op;
    word_t      es_src1;
    word_t      es_src2;
    word_t      es_rkd_value;
    logic       es_rf_we_r;
    logic [5:0] es_ds_except;
    logic       es_rdcnt_lo;
    logic       es_rdcnt_hi;
    dword_t     stable_cnt;
    word_t      alu_result;
    logic       is_load;
    logic       is_store;
    logic       is_mem;
    logic       is_div;
    logic       word_op;
    logic       half_op;
    logic       ale;
    logic       has_exc;
    logic       div_issued;
    strb_t      st_strb;

    assign es_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && es_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn || except_flush) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_valid && es_allowin) begin
            es_alu_op    <= ds_alu_op;
            es_md_op     <= ds_md_op;
            es_mem_op    <= ds_mem_op;
            es_src1      <= ds_src1;
            es_src2      <= ds_src2;
            es_rkd_value <= ds_rkd_value;
            es_rf_we_r   <= ds_rf_we;
            es_rf_waddr  <= ds_rf_waddr;
            es_pc        <= ds_pc;
            es_ds_except <= ds_except;
            es_rdcnt_lo  <= ds_rdcnt_lo;
            es_rdcnt_hi  <= ds_rdcnt_hi;
        end
    end

    // stable counter for rdcntvl.w / rdcntvh.w
    always_ff @(posedge clk) begin
        if (!resetn) begin
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 64'd1;
        end
    end

    alu u_alu (
        .alu_op     (es_alu_op),
        .alu_src1   (es_src1),
        .alu_src2   (es_src2),
        .alu_result (alu_result)
    );

    assign is_load  = es_mem_op inside {mem_ld_b, mem_ld_bu, mem_ld_h, mem_ld_hu, mem_ld_w};
    assign is_store = es_mem_op inside {mem_st_b, mem_st_h, mem_st_w};
    assign is_mem   = is_load || is_store;
    assign is_div   = md_is_div(es_md_op);
    assign word_op  = es_mem_op inside {mem_ld_w, mem_st_w};
    assign half_op  = es_mem_op inside {mem_ld_h, mem_ld_hu, mem_st_h};

    assign ale       = es_valid && ((word_op && |alu_result[1:0]) || (half_op && alu_result[0]));
    assign es_except = {ale, es_ds_except & {6{es_valid}}};
    assign has_exc   = |es_except;

    // excepted instructions pass straight through
    always_comb begin
        if (has_exc) begin
            es_ready_go = 1'b1;
        end else if (is_mem) begin
            es_ready_go = data_sram_req && data_sram_addr_ok;
        end else if (is_div) begin
            es_ready_go = div_issued && md.done;
        end else begin
            es_ready_go = 1'b1;
        end
    end

    // start once per divide, after the unit has drained
    assign md.start = es_valid && is_div && !has_exc && !except_flush
                      && !div_issued && !md.busy;
    assign md.op    = es_md_op;
    assign md.src1  = es_src1;
    assign md.src2  = es_src2;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            div_issued <= 1'b0;
        end else if (es_allowin) begin
            div_issued <= 1'b0;
        end else if (md.start) begin
            div_issued <= 1'b1;
        end
    end

    always_comb begin
        if (es_rdcnt_lo) begin
            es_result = stable_cnt[31:0];
        end else if (es_rdcnt_hi) begin
            es_result = stable_cnt[63:32];
        end else if (es_md_op != md_none) begin
            es_result = md.result;
        end else begin
            es_result = alu_result;
        end
    end

    assign es_rf_we        = es_rf_we_r && es_valid;
    assign es_res_from_mem = is_load && es_valid;

    always_comb begin
        case (es_mem_op)
            mem_st_b: st_strb = 4'b0001 << alu_result[1:0];
            mem_st_h: st_strb = alu_result[1] ? 4'b1100 : 4'b0011;
            mem_st_w: st_strb = 4'b1111;
            default:  st_strb = 4'b0000;
        endcase
    end

    always_comb begin
        case (es_mem_op)
            mem_st_b: data_sram_wdata = {4{es_rkd_value[7:0]}};
            mem_st_h: data_sram_wdata = {2{es_rkd_value[15:0]}};
            default:  data_sram_wdata = es_rkd_value;
        endcase
    end

    always_comb begin
        case (es_mem_op)
            mem_ld_b, mem_ld_bu, mem_st_b: data_sram_size = size_byte;
            mem_ld_h, mem_ld_hu, mem_st_h: data_sram_size = size_half;
            default:                       data_sram_size = size_word;
        endcase
    end

    assign data_sram_req   = es_valid && is_mem && !has_exc && !except_flush && ms_allowin;
    assign data_sram_wr    = data_sram_req && is_store;
    assign data_sram_wstrb = data_sram_wr ? st_strb : 4'b0000; // loads carry no strobe
    assign data_sram_addr  = alu_result;

endmodule

//--- hw/ex_top.sv
module ex_top
    import ex_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       ds_valid,
    output logic       es_allowin,
    input  alu_op_e    ds_alu_op,
    input  md_op_e     ds_md_op,
    input  mem_op_e    ds_mem_op,
    input  word_t      ds_src1,
    input  word_t      ds_src2,
    input  word_t      ds_rkd_value,
    input  logic       ds_rf_we,
    input  reg_addr_t  ds_rf_waddr,
    input  word_t      ds_pc,
    input  logic [5:0] ds_except,
    input  logic       ds_rdcnt_lo,
    input  logic       ds_rdcnt_hi,
    input  logic       ms_allowin,
    input  logic       except_flush,
    output logic       es_to_ms_valid,
    output word_t      es_pc,
    output word_t      es_result,
    output logic       es_rf_we,
    output reg_addr_t  es_rf_waddr,
    output logic       es_res_from_mem,
    output mem_op_e    es_mem_op,
    output except_t    es_except,
    output logic       data_sram_req,
    output logic       data_sram_wr,
    output size_t      data_sram_size,
    output strb_t      data_sram_wstrb,
    output word_t      data_sram_addr,
    output word_t      data_sram_wdata,
    input  logic       data_sram_addr_ok
);

    muldiv_if md_if ();

    ex_stage u_ex_stage (
        .clk               (clk),
        .resetn            (resetn),
        .ds_valid          (ds_valid),
        .es_allowin        (es_allowin),
        .ds_alu_op         (ds_alu_op),
        .ds_md_op          (ds_md_op),
        .ds_mem_op         (ds_mem_op),
        .ds_src1           (ds_src1),
        .ds_src2           (ds_src2),
        .ds_rkd_value      (ds_rkd_value),
        .ds_rf_we          (ds_rf_we),
        .ds_rf_waddr       (ds_rf_waddr),
        .ds_pc             (ds_pc),
        .ds_except         (ds_except),
        .ds_rdcnt_lo       (ds_rdcnt_lo),
        .ds_rdcnt_hi       (ds_rdcnt_hi),
        .ms_allowin        (ms_allowin),
        .except_flush      (except_flush),
        .es_to_ms_valid    (es_to_ms_valid),
        .es_pc             (es_pc),
        .es_result         (es_result),
        .es_rf_we          (es_rf_we),
        .es_rf_waddr       (es_rf_waddr),
        .es_res_from_mem   (es_res_from_mem),
        .es_mem_op         (es_mem_op),
        .es_except         (es_except),
        .data_sram_req     (data_sram_req),
        .data_sram_wr      (data_sram_wr),
        .data_sram_size    (data_sram_size),
        .data_sram_wstrb   (data_sram_wstrb),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_addr_ok (data_sram_addr_ok),
        .md                (md_if)
    );

    muldiv_unit u_muldiv_unit (
        .clk    (clk),
        .resetn (resetn),
        .md     (md_if)
    );

endmodule

//--- test/ex_top_sva.sv
module ex_top_sva
    import ex_pkg::*;
(
    input logic       clk,
    input logic       resetn,
    input logic       ds_valid,
    input logic       es_allowin,
    input md_op_e     ds_md_op,
    input mem_op_e    ds_mem_op,
    input logic [5:0] ds_except,
    input logic       except_flush,
    input logic       es_to_ms_valid,
    input except_t    es_except,
    input logic       data_sram_req,
    input logic       data_sram_addr_ok,
    input logic       ms_allowin,
    input logic       md_busy
);

    int sva_errors = 0;

    // request may only drop under back-pressure
    req_held: assert property (@(posedge clk) disable iff (!resetn || except_flush)
        data_sram_req && !data_sram_addr_ok |=> data_sram_req || !ms_allowin)
        else begin
            $error("sram request dropped before addr_ok");
            sva_errors++;
        end

    no_req_on_exc: assert property (@(posedge clk) disable iff (!resetn)
        (except_flush || |es_except) |-> !data_sram_req)
        else begin
            $error("sram request made under flush or exception");
            sva_errors++;
        end

    quiet_after_reset: assert property (@(posedge clk)
        !resetn |=> !es_to_ms_valid)
        else begin
            $error("stage output valid right after reset");
            sva_errors++;
        end

    // divider idle at acceptance, so the 33 cycle latency holds
    div_latency: assert property (@(posedge clk) disable iff (!resetn || except_flush)
        ds_valid && es_allowin && md_is_div(ds_md_op) && ds_mem_op == mem_none
        && ds_except == '0 && !md_busy |=> (!es_to_ms_valid)[*33] ##1 es_to_ms_valid)
        else begin
            $error("divide result not ready 33 cycles after acceptance");
            sva_errors++;
        end

endmodule

bind ex_top ex_top_sva u_ex_top_sva (
    .clk               (clk),
    .resetn            (resetn),
    .ds_valid          (ds_valid),
    .es_allowin        (es_allowin),
    .ds_md_op          (ds_md_op),
    .ds_mem_op         (ds_mem_op),
    .ds_except         (ds_except),
    .except_flush      (except_flush),
    .es_to_ms_valid    (es_to_ms_valid),
    .es_except         (es_except),
    .data_sram_req     (data_sram_req),
    .data_sram_addr_ok (data_sram_addr_ok),
    .ms_allowin        (ms_allowin),
    .md_busy           (md_if.busy)
);

//--- test/tb_ex_top.sv
module tb_ex_top
    import ex_pkg::*;
();

    localparam int num_instr  = 200;
    localparam int max_cycles = num_instr * 40;

    // dividend and divisor pairs for the directed divide cases
    localparam word_t div_a [7] = '{32'hffff_fff9, 32'd7, 32'hffff_fff9, 32'h8000_0000,
                                   32'd5, 32'hffff_fffb, 32'd0};
    localparam word_t div_b [7] = '{32'd2, 32'hffff_fffe, 32'hffff_fffe, 32'hffff_ffff,
                                   32'd0, 32'd0, 32'd3};

    typedef struct packed {
        word_t     pc;
        word_t     result;
        except_t   exc;
        reg_addr_t waddr;
        logic      rf_we;
        mem_op_e   mop;
        logic      cnt_lo;
        logic      cnt_hi;
        strb_t     strb;
        word_t     wdata;
        size_t     size;
    } exp_t;

    logic       clk = 1'b0;
    logic       resetn;
    logic       ds_valid;
    logic       es_allowin;
    alu_op_e    ds_alu_op;
    md_op_e     ds_md_op;
    mem_op_e    ds_mem_op;
    word_t      ds_src1;
    word_t      ds_src2;
    word_t      ds_rkd_value;
    logic       ds_rf_we;
    reg_addr_t  ds_rf_waddr;
    word_t      ds_pc;
    logic [5:0] ds_except;
    logic       ds_rdcnt_lo;
    logic       ds_rdcnt_hi;
    logic       ms_allowin;
    logic       except_flush;
    logic       es_to_ms_valid;
    word_t      es_pc;
    word_t      es_result;
    logic       es_rf_we;
    reg_addr_t  es_rf_waddr;
    logic       es_res_from_mem;
    mem_op_e    es_mem_op;
    except_t    es_except;
    logic       data_sram_req;
    logic       data_sram_wr;
    size_t      data_sram_size;
    strb_t      data_sram_wstrb;
    word_t      data_sram_addr;
    word_t      data_sram_wdata;
    logic       data_sram_addr_ok;

    exp_t  exp_q [$];
    int    errors  = 0;
    int    issued  = 0;
    int    retired = 0;
    int    flushed = 0;
    int    cycles  = 0;
    string cur_test = "reset";
    word_t last_lo  = '0;
    logic  stall_en = 1'b0;

    ex_top i_dut (.*);

    always #5 clk = ~clk;

    function automatic word_t alu_ref(alu_op_e op, word_t a, word_t b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_slt:  return {31'b0, $signed(a) < $signed(b)};
            alu_sltu: return {31'b0, a < b};
            alu_and:  return a & b;
            alu_nor:  return ~(a | b);
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return word_t'($signed(a) >>> b[4:0]);
            default:  return b; // lui
        endcase
    endfunction

    function automatic word_t muldiv_ref(md_op_e op, word_t a, word_t b);
        logic   sgn;
        word_t  ma;
        word_t  mb;
        word_t  q;
        word_t  r;
        dword_t p;
        sgn = (op == md_div) || (op == md_mod);
        ma  = (sgn && a[31]) ? -a : a;
        mb  = (sgn && b[31]) ? -b : b;
        if (mb == 0) begin
            q = '1; // restoring divider outcome for a zero divisor
            r = ma;
        end else begin
            q = ma / mb;
            r = ma % mb;
        end
        if (sgn && (a[31] ^ b[31])) q = -q;
        if (sgn && a[31]) r = -r;
        case (op)
            md_mul:   p = {32'b0, a * b};
            md_mulh:  p = dword_t'($signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b}));
            md_mulhu: p = {32'b0, a} * {32'b0, b};
            default:  p = '0;
        endcase
        case (op)
            md_mul:           return p[31:0];
            md_mulh, md_mulhu: return p[63:32];
            md_div, md_divu:  return q;
            default:          return r;
        endcase
    endfunction

    task automatic compare(input string what, input word_t exp, input word_t act);
        assert (exp == act) else begin
            errors++;
            $display("** Error [%s] %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic issue(input alu_op_e aop, input md_op_e mdop, input mem_op_e mop,
                         input word_t a, input word_t b, input word_t rkd,
                         input logic [5:0] dexc, input logic lo, input logic hi);
        exp_t  e;
        word_t addr;
        logic  ale;
        addr = a + b;
        ale  = ((mop == mem_ld_w || mop == mem_st_w) && addr[1:0] != 2'b00)
            || ((mop == mem_ld_h || mop == mem_ld_hu || mop == mem_st_h) && addr[0]);
        e.pc     = 32'h1c00_0000 + issued * 4;
        e.waddr  = reg_addr_t'(issued);
        e.rf_we  = (issued % 3) != 0;
        e.exc    = {ale, dexc};
        e.mop    = mop;
        e.cnt_lo = lo;
        e.cnt_hi = hi;
        if (mop != mem_none) e.result = addr;
        else if (mdop != md_none) e.result = muldiv_ref(mdop, a, b);
        else e.result = alu_ref(aop, a, b);
        e.strb = 4'b0000;
        case (mop)
            mem_st_b: e.strb[addr[1:0]] = 1'b1;
            mem_st_h: e.strb[{addr[1], 1'b0} +: 2] = 2'b11;
            mem_st_w: e.strb = 4'b1111;
            default:  ;
        endcase
        case (mop)
            mem_st_b: e.wdata = {4{rkd[7:0]}};
            mem_st_h: e.wdata = {2{rkd[15:0]}};
            default:  e.wdata = rkd;
        endcase
        if (mop inside {mem_ld_b, mem_ld_bu, mem_st_b}) e.size = size_byte;
        else if (mop inside {mem_ld_h, mem_ld_hu, mem_st_h}) e.size = size_half;
        else e.size = size_word;

        @(posedge clk);
        ds_valid     <= 1'b1;
        ds_alu_op    <= (mop != mem_none) ? alu_add : aop;
        ds_md_op     <= mdop;
        ds_mem_op    <= mop;
        ds_src1      <= a;
        ds_src2      <= b;
        ds_rkd_value <= rkd;
        ds_rf_we     <= e.rf_we;
        ds_rf_waddr  <= e.waddr;
        ds_pc        <= e.pc;
        ds_except    <= dexc;
        ds_rdcnt_lo  <= lo;
        ds_rdcnt_hi  <= hi;
        do @(posedge clk); while (!es_allowin || except_flush);
        ds_valid <= 1'b0;
        exp_q.push_back(e);
        issued++;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    // random back-pressure from memory and sram
    always @(posedge clk) begin
        if (stall_en) begin
            ms_allowin        <= ($urandom_range(0, 3) != 0);
            data_sram_addr_ok <= ($urandom_range(0, 2) != 0);
        end else begin
            ms_allowin        <= 1'b1;
            data_sram_addr_ok <= 1'b1;
        end
    end

    // memory-stage model checks sram fields before the pop
    always @(posedge clk) begin
        exp_t e;
        if (resetn && data_sram_req && data_sram_addr_ok) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("sram request with no instruction in flight, addr %h", data_sram_addr);
            end else begin
                e = exp_q[0];
                compare("addr", e.result, data_sram_addr);
                compare("wstrb", word_t'(e.strb), word_t'(data_sram_wstrb));
                compare("wr", word_t'(e.mop inside {mem_st_b, mem_st_h, mem_st_w}),
                        word_t'(data_sram_wr));
                compare("size", word_t'(e.size), word_t'(data_sram_size));
                if (data_sram_wr) compare("wdata", e.wdata, data_sram_wdata);
            end
        end
        if (resetn && es_to_ms_valid && ms_allowin) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("stage output with no instruction in flight, pc %h", es_pc);
            end else begin
                e = exp_q.pop_front();
                retired++;
                compare("pc", e.pc, es_pc);
                compare("except", word_t'(e.exc), word_t'(es_except));
                compare("waddr", word_t'(e.waddr), word_t'(es_rf_waddr));
                compare("rf_we", word_t'(e.rf_we), word_t'(es_rf_we));
                compare("mem_op", word_t'(e.mop), word_t'(es_mem_op));
                compare("res_from_mem",
                        word_t'(e.mop inside {mem_ld_b, mem_ld_bu, mem_ld_h, mem_ld_hu,
                                              mem_ld_w}),
                        word_t'(es_res_from_mem));
                if (e.cnt_lo) begin
                    // free-running counter, so strictly above the last read
                    assert (es_result > last_lo && es_result <= word_t'(cycles)) else begin
                        errors++;
                        $display("** Error [%s] cnt_lo: expected %h to %h, actual %h",
                                 cur_test, last_lo + 32'd1, word_t'(cycles), es_result);
                    end
                    last_lo = es_result;
                end else if (e.cnt_hi) begin
                    compare("cnt_hi", '0, es_result);
                end else begin
                    compare("result", e.result, es_result);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(29));
        resetn            = 1'b0;
        ds_valid          = 1'b0;
        ds_alu_op         = alu_add;
        ds_md_op          = md_none;
        ds_mem_op         = mem_none;
        ds_src1           = '0;
        ds_src2           = '0;
        ds_rkd_value      = '0;
        ds_rf_we          = 1'b0;
        ds_rf_waddr       = '0;
        ds_pc             = '0;
        ds_except         = '0;
        ds_rdcnt_lo       = 1'b0;
        ds_rdcnt_hi       = 1'b0;
        ms_allowin        = 1'b1;
        except_flush      = 1'b0;
        data_sram_addr_ok = 1'b0;
        repeat (5) @(posedge clk);
        resetn   <= 1'b1;
        stall_en <= 1'b1;

        cur_test = "alu";
        repeat (60) issue(alu_op_e'($urandom_range(0, 11)), md_none, mem_none,
                          $urandom, $urandom, '0, '0, 1'b0, 1'b0);
        drain();

        cur_test = "muldiv";
        repeat (20) issue(alu_add, md_op_e'($urandom_range(1, 3)), mem_none,
                          $urandom, $urandom, '0, '0, 1'b0, 1'b0);
        for (int op = 4; op < 8; op++) begin
            for (int i = 0; i < 7; i++) begin
                issue(alu_add, md_op_e'(op), mem_none, div_a[i], div_b[i], '0, '0, 1'b0, 1'b0);
            end
        end
        repeat (8) issue(alu_add, md_op_e'($urandom_range(4, 7)), mem_none,
                         $urandom, $urandom_range(1, 1000), '0, '0, 1'b0, 1'b0);
        drain();

        cur_test = "mem";
        repeat (50) issue(alu_add, md_none, mem_op_e'($urandom_range(1, 8)),
                          $urandom & 32'hffff_fff0, $urandom_range(0, 7), $urandom,
                          ($urandom_range(0, 9) == 0) ? 6'h01 << $urandom_range(0, 5) : 6'h00,
                          1'b0, 1'b0);
        drain();

        // all-ones alu result, never a counter value this early
        cur_test = "rdcnt";
        repeat (20) begin
            if ($urandom_range(0, 1) == 1) begin
                issue(alu_add, md_none, mem_none, 32'hffff_ffff, '0, '0, '0, 1'b1, 1'b0);
            end else begin
                issue(alu_add, md_none, mem_none, 32'hffff_ffff, '0, '0, '0, 1'b0, 1'b1);
            end
        end
        drain();

        // a divide in flight is dropped by the flush
        cur_test = "flush";
        stall_en <= 1'b0;
        issue(alu_add, md_div, mem_none, 32'd100, 32'd7, '0, '0, 1'b0, 1'b0);
        repeat (5) @(posedge clk);
        except_flush <= 1'b1;
        @(posedge clk);
        except_flush <= 1'b0;
        exp_q.delete(0);
        flushed++;
        issue(alu_add, md_divu, mem_none, 32'd100, 32'd7, '0, '0, 1'b0, 1'b0);
        drain();
        repeat (5) @(posedge clk);

        assert (issued == retired + flushed) else begin
            errors++;
            $display("instruction count mismatch: %0d issued, %0d retired, %0d flushed",
                     issued, retired, flushed);
        end
        $display("errors: %0d checks, %0d assertions", errors, i_dut.u_ex_top_sva.sva_errors);
        if (errors == 0 && i_dut.u_ex_top_sva.sva_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- ex_top.f
hw/ex_pkg.sv
hw/muldiv_if.sv
hw/alu.sv
hw/muldiv_unit.sv
hw/ex_stage.sv
hw/ex_top.sv
test/ex_top_sva.sv
test/tb_ex_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ex_top
FILELIST  ?= ex_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
